/* all.f */
+incdir+include
src/dram_pkg.sv
src/axi_slave_if.sv
src/dram_bus_if.sv
src/dram_ctrl.sv
src/dram_array.sv
src/dram_subsys_top.sv
tb/tb_dram_subsys.sv

/* Bender.yml */
package:
  name: dram_subsys

sources:
  - include_dirs:
      - include
    files:
      - src/dram_pkg.sv
      - src/axi_slave_if.sv
      - src/dram_bus_if.sv
      - src/dram_ctrl.sv
      - src/dram_array.sv
      - src/dram_subsys_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_dram_subsys.sv

/* tb/tb_dram_subsys.sv */
`timescale 1ns/1ps
`include "dram_defs.svh"

module tb_dram_subsys;

  localparam int TIMEOUT = 200;

  logic clk;
  logic rstn;
  dram_pkg::axi_id_t awid;
  dram_pkg::axi_addr_t awaddr;
  logic awvalid;
  logic awready;
  dram_pkg::axi_data_t wdata;
  dram_pkg::axi_strb_t wstrb;
  logic wvalid;
  logic wready;
  dram_pkg::axi_id_t bid;
  dram_pkg::axi_resp_t bresp;
  logic bvalid;
  logic bready;
  dram_pkg::axi_id_t arid;
  dram_pkg::axi_addr_t araddr;
  logic arvalid;
  logic arready;
  dram_pkg::axi_id_t rid;
  dram_pkg::axi_data_t rdata;
  dram_pkg::axi_resp_t rresp;
  logic rvalid;
  logic rready;

  // Word contents as written so far
  dram_pkg::axi_data_t shadow [int unsigned];
  dram_pkg::axi_id_t exp_bid [$];
  dram_pkg::axi_id_t exp_rid [$];
  dram_pkg::axi_data_t exp_rdata [$];
  dram_pkg::axi_addr_t used_addr [$];
  integer seed = 32'hb94684d8;
  int n_sent;
  int n_checked;

  dram_subsys_top i_dram_subsys_top (
    .clk    (clk),
    .rstn   (rstn),
    .awid   (awid),
    .awaddr (awaddr),
    .awvalid(awvalid),
    .awready(awready),
    .wdata  (wdata),
    .wstrb  (wstrb),
    .wvalid (wvalid),
    .wready (wready),
    .bid    (bid),
    .bresp  (bresp),
    .bvalid (bvalid),
    .bready (bready),
    .arid   (arid),
    .araddr (araddr),
    .arvalid(arvalid),
    .arready(arready),
    .rid    (rid),
    .rdata  (rdata),
    .rresp  (rresp),
    .rvalid (rvalid),
    .rready (rready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic dram_pkg::axi_addr_t make_addr(input int row, input int col);
    return (dram_pkg::axi_addr_t'(row) << (2 + `DRAM_COL_BITS)) |
           (dram_pkg::axi_addr_t'(col) << 2);
  endfunction

  function automatic dram_pkg::axi_addr_t random_addr();
    logic [1:0] row;
    logic [`DRAM_COL_BITS-1:0] col;
    row = $random(seed);
    col = $random(seed);
    return make_addr(row, col);
  endfunction

  // Row and column bits form the word key
  function automatic int unsigned word_key(input dram_pkg::axi_addr_t addr);
    return addr[22:2];
  endfunction

  function automatic dram_pkg::axi_data_t expected_read(input dram_pkg::axi_addr_t addr);
    if (shadow.exists(word_key(addr))) begin
      return shadow[word_key(addr)];
    end
    return '0;
  endfunction

  function automatic dram_pkg::axi_data_t merge_bytes(input dram_pkg::axi_data_t old,
                                                     input dram_pkg::axi_data_t data,
                                                     input dram_pkg::axi_strb_t strb);
    dram_pkg::axi_data_t res;
    res = old;
    for (int i = 0; i < `AXI_STRB_BITS; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = data[8*i +: 8];
      end
    end
    return res;
  endfunction

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input dram_pkg::axi_data_t exp,
                            input dram_pkg::axi_data_t act);
    if (act !== exp) begin
      stop_with_failure($sformatf("ERROR at %0t: %s expected %h, got %h",
                                  $time, name, exp, act));
    end
  endtask

  task automatic check_id(input string name, input dram_pkg::axi_id_t exp,
                          input dram_pkg::axi_id_t act);
    if (act !== exp) begin
      stop_with_failure($sformatf("ERROR at %0t: %s expected %h, got %h",
                                  $time, name, exp, act));
    end
  endtask

  task automatic check_resp(input string name, input dram_pkg::axi_resp_t exp,
                            input dram_pkg::axi_resp_t act);
    if (act !== exp) begin
      stop_with_failure($sformatf("ERROR at %0t: %s expected %h, got %h",
                                  $time, name, exp, act));
    end
  endtask

  task automatic offer_write(input dram_pkg::axi_addr_t addr, input dram_pkg::axi_data_t data,
                             input dram_pkg::axi_strb_t strb, input dram_pkg::axi_id_t id);
    awid = id;
    awaddr = addr;
    awvalid = 1'b1;
    wdata = data;
    wstrb = strb;
    wvalid = 1'b1;
  endtask

  task automatic finish_write();
    int t;
    t = 0;
    @(negedge clk);
    while (!(awready && wready)) begin
      t++;
      if (t > TIMEOUT) stop_with_failure("Timeout waiting for awready and wready");
      @(negedge clk);
    end
    // Write has priority over a read offered alongside
    if (arvalid && arready) stop_with_failure("Read accepted in the same cycle as a write");
    @(posedge clk);
    #1;
    awvalid = 1'b0;
    wvalid = 1'b0;
    shadow[word_key(awaddr)] = merge_bytes(expected_read(awaddr), wdata, wstrb);
    exp_bid.push_back(awid);
    n_sent++;
  endtask

  task automatic offer_read(input dram_pkg::axi_addr_t addr, input dram_pkg::axi_id_t id);
    araddr = addr;
    arid = id;
    arvalid = 1'b1;
  endtask

  task automatic finish_read();
    int t;
    t = 0;
    @(negedge clk);
    while (!arready) begin
      t++;
      if (t > TIMEOUT) stop_with_failure("Timeout waiting for arready");
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    arvalid = 1'b0;
    exp_rid.push_back(arid);
    exp_rdata.push_back(expected_read(araddr));
    n_sent++;
  endtask

  task automatic take_bresp();
    int t;
    int hold;
    t = 0;
    @(negedge clk);
    while (!bvalid) begin
      t++;
      if (t > TIMEOUT) stop_with_failure("Timeout waiting for bvalid");
      @(negedge clk);
    end
    hold = $random(seed) & 7;
    repeat (hold) begin
      @(negedge clk);
      if (!bvalid) stop_with_failure("bvalid dropped before bready");
      check_id("bid", exp_bid[0], bid);
      check_resp("bresp", dram_pkg::AXI_RESP_OKAY, bresp);
      if (awready || wready || arready) begin
        stop_with_failure("Request accepted during a pending write response");
      end
    end
    @(posedge clk);
    #1;
    bready = 1'b1;
    @(posedge clk);
    #1;
    bready = 1'b0;
  endtask

  task automatic take_rresp();
    int t;
    int hold;
    t = 0;
    @(negedge clk);
    while (!rvalid) begin
      t++;
      if (t > TIMEOUT) stop_with_failure("Timeout waiting for rvalid");
      @(negedge clk);
    end
    hold = $random(seed) & 7;
    repeat (hold) begin
      @(negedge clk);
      if (!rvalid) stop_with_failure("rvalid dropped before rready");
      check_id("rid", exp_rid[0], rid);
      check_data("rdata", exp_rdata[0], rdata);
      check_resp("rresp", dram_pkg::AXI_RESP_OKAY, rresp);
      if (awready || wready || arready) begin
        stop_with_failure("Request accepted during a pending read response");
      end
    end
    @(posedge clk);
    #1;
    rready = 1'b1;
    @(posedge clk);
    #1;
    rready = 1'b0;
  endtask

  task automatic do_write(input dram_pkg::axi_addr_t addr, input dram_pkg::axi_data_t data,
                          input dram_pkg::axi_strb_t strb, input dram_pkg::axi_id_t id);
    @(posedge clk);
    #1;
    offer_write(addr, data, strb, id);
    finish_write();
    take_bresp();
  endtask

  task automatic do_read(input dram_pkg::axi_addr_t addr, input dram_pkg::axi_id_t id);
    @(posedge clk);
    #1;
    offer_read(addr, id);
    finish_read();
    take_rresp();
  endtask

  // Compares each response in the cycle before its handshake edge
  always @(negedge clk) begin : compare_responses
    if (rstn && bvalid && bready) begin
      if (exp_bid.size() == 0) stop_with_failure("Write response with no write outstanding");
      check_id("bid", exp_bid.pop_front(), bid);
      check_resp("bresp", dram_pkg::AXI_RESP_OKAY, bresp);
      n_checked++;
    end
    if (rstn && rvalid && rready) begin
      if (exp_rid.size() == 0) stop_with_failure("Read response with no read outstanding");
      check_id("rid", exp_rid.pop_front(), rid);
      check_data("rdata", exp_rdata.pop_front(), rdata);
      check_resp("rresp", dram_pkg::AXI_RESP_OKAY, rresp);
      n_checked++;
    end
  end

  initial begin
    int rows [9];
    dram_pkg::axi_addr_t addr;
    dram_pkg::axi_strb_t strb;
    rows = '{0, 1, 0, 2, 3, 3, 3, 1, 1};
    rstn = 1'b0;
    awid = '0;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    wvalid = 1'b0;
    bready = 1'b0;
    arid = '0;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    n_sent = 0;
    n_checked = 0;
    repeat (5) @(posedge clk);
    #1;
    rstn = 1'b1;
    @(negedge clk);
    if (rvalid || bvalid) stop_with_failure("Response valid right after reset");
    if (!awready) stop_with_failure("awready low right after reset");

    // Untouched memory reads zero
    do_read(make_addr(2, 10'h3ff), 4'h1);
    do_read(make_addr(0, 0), 4'h2);

    for (int i = 0; i < 12; i++) begin
      addr = random_addr();
      used_addr.push_back(addr);
      do_write(addr, $random(seed), '1, dram_pkg::axi_id_t'($random(seed)));
    end
    foreach (used_addr[i]) begin
      do_read(used_addr[i], dram_pkg::axi_id_t'($random(seed)));
    end

    // Byte merges on earlier words
    for (int i = 0; i < 8; i++) begin
      addr = used_addr[$unsigned($random(seed)) % used_addr.size()];
      strb = $random(seed);
      if (strb == '0) strb = 4'b0010;
      do_write(addr, $random(seed), strb, dram_pkg::axi_id_t'(i));
      do_read(addr, dram_pkg::axi_id_t'(i + 8));
    end

    // Row miss, change and hit
    foreach (rows[i]) begin
      do_write(make_addr(rows[i], 10'h20 + i), $random(seed), '1, dram_pkg::axi_id_t'(i));
    end
    foreach (rows[i]) begin
      do_read(make_addr(rows[i], 10'h20 + i), dram_pkg::axi_id_t'(15 - i));
    end

    // AW and AR in the same cycle
    for (int i = 0; i < 3; i++) begin
      addr = used_addr[i];
      @(posedge clk);
      #1;
      offer_read(addr, 4'hc);
      offer_write(addr, $random(seed), '1, 4'h3);
      finish_write();
      take_bresp();
      finish_read();
      take_rresp();
    end

    repeat (4) @(posedge clk);
    if (n_checked != n_sent || exp_bid.size() != 0 || exp_rid.size() != 0) begin
      $display("Responses missing, %0d sent and %0d checked", n_sent, n_checked);
      $display("Testbench failed");
      $fatal(1);
    end else begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule

/* src/dram_subsys_top.sv */
`timescale 1ns/1ps

module dram_subsys_top (
  input logic clk,
  input logic rstn,
  input dram_pkg::axi_id_t awid,
  input dram_pkg::axi_addr_t awaddr,
  input logic awvalid,
  output logic awready,
  input dram_pkg::axi_data_t wdata,
  input dram_pkg::axi_strb_t wstrb,
  input logic wvalid,
  output logic wready,
  output dram_pkg::axi_id_t bid,
  output dram_pkg::axi_resp_t bresp,
  output logic bvalid,
  input logic bready,
  input dram_pkg::axi_id_t arid,
  input dram_pkg::axi_addr_t araddr,
  input logic arvalid,
  output logic arready,
  output dram_pkg::axi_id_t rid,
  output dram_pkg::axi_data_t rdata,
  output dram_pkg::axi_resp_t rresp,
  output logic rvalid,
  input logic rready
);

  axi_slave_if axi ();
  dram_bus_if dram ();

  // Master side from the pins
  assign axi.awid = awid;
  assign axi.awaddr = awaddr;
  assign axi.awvalid = awvalid;
  assign axi.wdata = wdata;
  assign axi.wstrb = wstrb;
  assign axi.wvalid = wvalid;
  assign axi.bready = bready;
  assign axi.arid = arid;
  assign axi.araddr = araddr;
  assign axi.arvalid = arvalid;
  assign axi.rready = rready;

  assign awready = axi.awready;
  assign wready = axi.wready;
  assign bid = axi.bid;
  assign bresp = axi.bresp;
  assign bvalid = axi.bvalid;
  assign arready = axi.arready;
  assign rid = axi.rid;
  assign rdata = axi.rdata;
  assign rresp = axi.rresp;
  assign rvalid = axi.rvalid;

  dram_ctrl i_dram_ctrl (
    .clk (clk),
    .rstn(rstn),
    .axi (axi.slave),
    .dram(dram.ctrl)
  );

  dram_array i_dram_array (
    .clk (clk),
    .rstn(rstn),
    .dram(dram.dev)
  );

endmodule

/* src/dram_array.sv */
`timescale 1ns/1ps
`include "dram_defs.svh"

module dram_array (
  input logic clk,
  input logic rstn,
  dram_bus_if.dev dram
);

  localparam int ROW_IDX_BITS = $clog2(`DRAM_MODEL_ROWS);
  localparam int WORDS = `DRAM_MODEL_ROWS << `DRAM_COL_BITS;

  // Contents start cleared
  dram_pkg::axi_data_t mem [WORDS] = '{default: '0};
  dram_pkg::axi_data_t rd_pipe [`DRAM_T_CL];

  logic [`DRAM_T_CL-1:0] vld_pipe;
  logic [ROW_IDX_BITS-1:0] row_idx;
  logic row_open;
  logic ras_cmd;
  logic cas_cmd;
  logic pre_cmd;
  logic wr_cmd;
  logic [ROW_IDX_BITS+`DRAM_COL_BITS-1:0] word_idx;

  assign ras_cmd = !dram.csn && !dram.rasn;
  assign cas_cmd = !dram.csn && !dram.casn;
  // Precharge is RAS with write enables low
  assign pre_cmd = ras_cmd && (dram.wen == '0);
  assign wr_cmd = cas_cmd && (dram.wen != '1);
  assign word_idx = {row_idx, dram.a.col.addr};

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      row_open <= 1'b0;
    end else if (pre_cmd) begin
      row_open <= 1'b0;
    end else if (ras_cmd) begin
      row_open <= 1'b1;
    end
  end

  // Upper row bits alias
  always_ff @(posedge clk) begin
    if (ras_cmd && !pre_cmd) begin
      row_idx <= dram.a.row[ROW_IDX_BITS-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (wr_cmd) begin
      for (int i = 0; i < `AXI_STRB_BITS; i++) begin
        if (!dram.wen[i]) begin
          mem[word_idx][8*i +: 8] <= dram.d[8*i +: 8];
        end
      end
    end
  end

  // CAS latency pipe
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe <= (vld_pipe << 1) | `DRAM_T_CL'(cas_cmd && !wr_cmd);
    end
  end

  always_ff @(posedge clk) begin
    rd_pipe[0] <= mem[word_idx];
    for (int s = 1; s < `DRAM_T_CL; s++) begin
      rd_pipe[s] <= rd_pipe[s-1];
    end
  end

  assign dram.q = rd_pipe[`DRAM_T_CL-1];
  assign dram.q_valid = vld_pipe[`DRAM_T_CL-1];

  a_cas_row_open: assert property (@(posedge clk) disable iff (!rstn)
    cas_cmd |-> row_open)
    else $error("CAS issued with no open row");

endmodule

/* src/dram_ctrl.sv */
`timescale 1ns/1ps
`include "dram_defs.svh"

module dram_ctrl (
  input logic clk,
  input logic rstn,
  axi_slave_if.slave axi,
  dram_bus_if.ctrl dram
);

  localparam int BYTE_OFS = $clog2(`AXI_STRB_BITS);
  localparam int ROW_LSB = BYTE_OFS + `DRAM_COL_BITS;
  localparam int RCD_W = $clog2(`DRAM_T_RCD) + 1;

  dram_pkg::ctrl_state_t state;
  dram_pkg::ctrl_state_t state_nx;
  dram_pkg::dram_op_t op_r;
  dram_pkg::axi_id_t id_r;
  dram_pkg::axi_addr_t addr_r;
  dram_pkg::axi_data_t wdata_r;
  dram_pkg::axi_strb_t strb_r;
  dram_pkg::axi_data_t rdata_r;
  dram_pkg::axi_addr_t req_addr;
  dram_pkg::axi_strb_t wen_n;
  dram_pkg::dram_a_u a_w;

  logic [`DRAM_ROW_BITS-1:0] req_row;
  logic [`DRAM_ROW_BITS-1:0] open_row;
  logic row_open;
  logic [RCD_W-1:0] rcd_cnt;
  logic cas_sent;
  logic ras_cmd;
  logic cas_cmd;
  logic aw_hs;
  logic w_hs;
  logic ar_hs;
  logic b_hs;
  logic r_hs;

  // Where a held request goes, based on the open row
  function automatic dram_pkg::ctrl_state_t route(input logic [`DRAM_ROW_BITS-1:0] row,
                                                  input logic is_open,
                                                  input logic [`DRAM_ROW_BITS-1:0] cur);
    if (!is_open) begin
      return dram_pkg::S_ACT;
    end else if (row != cur) begin
      return dram_pkg::S_PRE;
    end
    return dram_pkg::S_ACCESS;
  endfunction

  assign aw_hs = axi.awvalid & axi.awready;
  assign w_hs = axi.wvalid & axi.wready;
  assign ar_hs = axi.arvalid & axi.arready;
  assign b_hs = axi.bvalid & axi.bready;
  assign r_hs = axi.rvalid & axi.rready;

  // Incoming address in idle, latched one afterwards
  assign req_addr = aw_hs ? axi.awaddr : (ar_hs ? axi.araddr : addr_r);
  assign req_row = req_addr[ROW_LSB +: `DRAM_ROW_BITS];

  assign axi.bid = id_r;
  assign axi.rid = id_r;
  assign axi.bresp = dram_pkg::AXI_RESP_OKAY;
  assign axi.rresp = dram_pkg::AXI_RESP_OKAY;
  assign axi.rdata = rdata_r;

  // Write wins when AW and AR arrive together
  always_comb begin
    axi.awready = 1'b0;
    axi.wready = 1'b0;
    axi.arready = 1'b0;
    axi.bvalid = 1'b0;
    axi.rvalid = 1'b0;
    case (state)
      dram_pkg::S_IDLE: begin
        axi.awready = 1'b1;
        axi.wready = axi.awvalid;
        axi.arready = ~axi.awvalid;
      end
      dram_pkg::S_WAIT_W: axi.wready = 1'b1;
      dram_pkg::S_RESP: begin
        axi.bvalid = (op_r == dram_pkg::OP_WRITE);
        axi.rvalid = (op_r == dram_pkg::OP_READ);
      end
      default: ;
    endcase
  end

  always_comb begin
    state_nx = state;
    case (state)
      dram_pkg::S_IDLE: begin
        if (aw_hs) begin
          state_nx = w_hs ? route(req_row, row_open, open_row) : dram_pkg::S_WAIT_W;
        end else if (ar_hs) begin
          state_nx = route(req_row, row_open, open_row);
        end
      end
      dram_pkg::S_WAIT_W: begin
        if (w_hs) begin
          state_nx = route(req_row, row_open, open_row);
        end
      end
      dram_pkg::S_PRE: state_nx = dram_pkg::S_ACT;
      dram_pkg::S_ACT: state_nx = (`DRAM_T_RCD > 1) ? dram_pkg::S_RCD : dram_pkg::S_ACCESS;
      dram_pkg::S_RCD: begin
        if (rcd_cnt == RCD_W'(1)) begin
          state_nx = dram_pkg::S_ACCESS;
        end
      end
      dram_pkg::S_ACCESS: begin
        if (op_r == dram_pkg::OP_WRITE) begin
          state_nx = dram_pkg::S_RESP;
        end else if (cas_sent && dram.q_valid) begin
          state_nx = dram_pkg::S_RESP;
        end
      end
      dram_pkg::S_RESP: begin
        if (b_hs || r_hs) begin
          state_nx = dram_pkg::S_IDLE;
        end
      end
      default: state_nx = dram_pkg::S_IDLE;
    endcase
  end

  // DRAM command decode
  always_comb begin
    ras_cmd = 1'b0;
    cas_cmd = 1'b0;
    wen_n = '1;
    a_w = '0;
    case (state)
      dram_pkg::S_PRE: begin
        ras_cmd = 1'b1;
        wen_n = '0;
        a_w.row = open_row;
      end
      dram_pkg::S_ACT: begin
        ras_cmd = 1'b1;
        a_w.row = req_row;
      end
      dram_pkg::S_ACCESS: begin
        a_w.col.addr = addr_r[BYTE_OFS +: `DRAM_COL_BITS];
        if (op_r == dram_pkg::OP_WRITE) begin
          cas_cmd = 1'b1;
          wen_n = ~strb_r;
        end else begin
          cas_cmd = ~cas_sent;
        end
      end
      default: ;
    endcase
  end

  assign dram.csn = ~(ras_cmd | cas_cmd);
  assign dram.rasn = ~ras_cmd;
  assign dram.casn = ~cas_cmd;
  assign dram.wen = wen_n;
  assign dram.a = a_w;
  assign dram.d = wdata_r;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= dram_pkg::S_IDLE;
      op_r <= dram_pkg::OP_NONE;
      row_open <= 1'b0;
      rcd_cnt <= '0;
      cas_sent <= 1'b0;
    end else begin
      state <= state_nx;
      if (aw_hs) begin
        op_r <= dram_pkg::OP_WRITE;
      end else if (ar_hs) begin
        op_r <= dram_pkg::OP_READ;
      end else if (b_hs || r_hs) begin
        op_r <= dram_pkg::OP_NONE;
      end
      if (state == dram_pkg::S_PRE) begin
        row_open <= 1'b0;
      end else if (state == dram_pkg::S_ACT) begin
        row_open <= 1'b1;
      end
      if (state == dram_pkg::S_ACT) begin
        rcd_cnt <= RCD_W'(`DRAM_T_RCD - 1);
      end else if (state == dram_pkg::S_RCD) begin
        rcd_cnt <= rcd_cnt - RCD_W'(1);
      end
      // Read CAS goes out once per access
      cas_sent <= (state == dram_pkg::S_ACCESS) && (cas_sent || cas_cmd);
    end
  end

  always_ff @(posedge clk) begin
    if (aw_hs) begin
      id_r <= axi.awid;
      addr_r <= axi.awaddr;
    end else if (ar_hs) begin
      id_r <= axi.arid;
      addr_r <= axi.araddr;
    end
    if (w_hs) begin
      wdata_r <= axi.wdata;
      strb_r <= axi.wstrb;
    end
    if (state == dram_pkg::S_ACT) begin
      open_row <= req_row;
    end
    if (state == dram_pkg::S_ACCESS && dram.q_valid) begin
      rdata_r <= dram.q;
    end
  end

  a_ras_cas_excl: assert property (@(posedge clk) disable iff (!rstn)
    dram.rasn || dram.casn)
    else $error("RAS and CAS asserted together");

  a_rvalid_hold: assert property (@(posedge clk) disable iff (!rstn)
    axi.rvalid && !axi.rready |=> axi.rvalid && $stable(axi.rdata) && $stable(axi.rid))
    else $error("R channel dropped or changed before rready");

  a_bvalid_hold: assert property (@(posedge clk) disable iff (!rstn)
    axi.bvalid && !axi.bready |=> axi.bvalid && $stable(axi.bid) && $stable(axi.bresp))
    else $error("B channel dropped or changed before bready");

  a_rcd_met: assert property (@(posedge clk) disable iff (!rstn)
    (state == dram_pkg::S_ACCESS) && ($past(state) != dram_pkg::S_ACCESS) |-> rcd_cnt == '0)
    else $error("Access entered before tRCD elapsed");

endmodule

/* src/dram_bus_if.sv */
`timescale 1ns/1ps

interface dram_bus_if;

  // Strobes are active low
  logic csn;
  logic rasn;
  logic casn;
  dram_pkg::axi_strb_t wen;
  dram_pkg::dram_a_u a;
  dram_pkg::axi_data_t d;
  dram_pkg::axi_data_t q;
  logic q_valid;

  modport ctrl (
    output csn, rasn, casn, wen, a, d,
    input q, q_valid
  );

  modport dev (
    input csn, rasn, casn, wen, a, d,
    output q, q_valid
  );

endinterface

/* src/axi_slave_if.sv */
`timescale 1ns/1ps

interface axi_slave_if;

  dram_pkg::axi_id_t awid;
  dram_pkg::axi_addr_t awaddr;
  logic awvalid;
  logic awready;
  dram_pkg::axi_data_t wdata;
  dram_pkg::axi_strb_t wstrb;
  logic wvalid;
  logic wready;
  dram_pkg::axi_id_t bid;
  dram_pkg::axi_resp_t bresp;
  logic bvalid;
  logic bready;
  dram_pkg::axi_id_t arid;
  dram_pkg::axi_addr_t araddr;
  logic arvalid;
  logic arready;
  dram_pkg::axi_id_t rid;
  dram_pkg::axi_data_t rdata;
  dram_pkg::axi_resp_t rresp;
  logic rvalid;
  logic rready;

  modport master (
    output awid, awaddr, awvalid, wdata, wstrb, wvalid, bready, arid, araddr, arvalid, rready,
    input awready, wready, bid, bresp, bvalid, arready, rid, rdata, rresp, rvalid
  );

  modport slave (
    input awid, awaddr, awvalid, wdata, wstrb, wvalid, bready, arid, araddr, arvalid, rready,
    output awready, wready, bid, bresp, bvalid, arready, rid, rdata, rresp, rvalid
  );

endinterface

/* src/dram_pkg.sv */
`include "dram_defs.svh"

package dram_pkg;

  typedef logic [`AXI_ID_BITS-1:0] axi_id_t;
  typedef logic [`AXI_ADDR_BITS-1:0] axi_addr_t;
  typedef logic [`AXI_DATA_BITS-1:0] axi_data_t;
  typedef logic [`AXI_STRB_BITS-1:0] axi_strb_t;
  typedef logic [1:0] axi_resp_t;

  localparam axi_resp_t AXI_RESP_OKAY = 2'b00;

  // Row view during RAS and column view during CAS on the same pins
  typedef union packed {
    logic [`DRAM_A_BITS-1:0] row;
    struct packed {
      logic [`DRAM_A_BITS-`DRAM_COL_BITS-1:0] pad;
      logic [`DRAM_COL_BITS-1:0] addr;
    } col;
  } dram_a_u;

  typedef enum logic [1:0] {
    OP_NONE,
    OP_READ,
    OP_WRITE
  } dram_op_t;

  typedef enum logic [2:0] {
    S_IDLE,
    S_WAIT_W,
    S_PRE,
    S_ACT,
    S_RCD,
    S_ACCESS,
    S_RESP
  } ctrl_state_t;

endpackage

/* include/dram_defs.svh */
`ifndef DRAM_DEFS_SVH
`define DRAM_DEFS_SVH

// AXI channel widths
`define AXI_ID_BITS 4
`define AXI_ADDR_BITS 32
`define AXI_DATA_BITS 32
`define AXI_STRB_BITS 4

// Row sits in address bits 22:12, column in 11:2
`define DRAM_ROW_BITS 11
`define DRAM_COL_BITS 10

// Address pins carry the row on RAS, the column on CAS
`define DRAM_A_BITS `DRAM_ROW_BITS

// RAS to first CAS
`define DRAM_T_RCD 3

// Read CAS to data
`define DRAM_T_CL 2

// Rows kept by the behavioral array
`define DRAM_MODEL_ROWS 4

`endif
